/* filelist.f */
common/dcache_pkg.sv
common/cache_req_if.sv
rtl/dcache_decode.sv
cache_ctrl/dcache_arrays.sv
cache_ctrl/dcache_ctrl.sv
rtl/dcache_result.sv
rtl/dcache_top.sv
verif/mem_model.sv
verif/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module dcache_tb \
    -Mdir "$build_dir" -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vdcache_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    exit 1
fi
exit 0

/* verif/dcache_tb.sv */
`default_nettype none

module dcache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int index_bits     = 4;
    localparam int timeout_cycles = 300;

    logic                             clk;
    logic                             reset;
    logic                             req_valid;
    logic                             req_write;
    logic [31:0]                      req_addr;
    logic [31:0]                      req_wdata;
    logic [3:0]                       req_wstrb;
    logic [31:0]                      rdata;
    logic                             busy;
    logic                             mem_rd_req;
    logic [31:0]                      mem_rd_addr;
    logic                             mem_rd_rdy;
    logic                             mem_ret_valid;
    logic [dcache_pkg::line_bits-1:0] mem_ret_data;
    logic                             mem_wr_req;
    logic [31:0]                      mem_wr_addr;
    logic [dcache_pkg::line_bits-1:0] mem_wr_data;
    logic                             mem_wr_rdy;
    logic                             mem_wr_done;
    int                               wb_count;
    logic [31:0]                      last_wb_addr;
    logic [dcache_pkg::line_bits-1:0] last_wb_data;
    logic [31:0]                      last_rd_addr;

    logic [7:0] golden [16384];  // memory as the cpu sees it
    integer     seed;
    int         cycle_cnt = 0;
    int         check_count;
    int         error_count;
    int         test_count;
    bit         timed_out;

    // accepted requests still waiting for their result
    string       exp_name [$];
    logic [31:0] exp_data [$];
    bit          exp_load [$];
    bit          exp_fast [$];
    int          exp_cycle [$];

    dcache_top #(.index_bits(index_bits)) dcache_top_inst (
        .clk (clk), .reset (reset),
        .req_valid (req_valid), .req_write (req_write), .req_addr (req_addr),
        .req_wdata (req_wdata), .req_wstrb (req_wstrb), .rdata (rdata), .busy (busy),
        .mem_rd_req (mem_rd_req), .mem_rd_addr (mem_rd_addr), .mem_rd_rdy (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid), .mem_ret_data (mem_ret_data),
        .mem_wr_req (mem_wr_req), .mem_wr_addr (mem_wr_addr), .mem_wr_data (mem_wr_data),
        .mem_wr_rdy (mem_wr_rdy), .mem_wr_done (mem_wr_done)
    );

    mem_model mem_inst (
        .clk (clk), .reset (reset),
        .mem_rd_req (mem_rd_req), .mem_rd_addr (mem_rd_addr), .mem_rd_rdy (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid), .mem_ret_data (mem_ret_data),
        .mem_wr_req (mem_wr_req), .mem_wr_addr (mem_wr_addr), .mem_wr_data (mem_wr_data),
        .mem_wr_rdy (mem_wr_rdy), .mem_wr_done (mem_wr_done),
        .wb_count (wb_count), .last_wb_addr (last_wb_addr), .last_wb_data (last_wb_data),
        .last_rd_addr (last_rd_addr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [31:0] pattern_word(logic [31:0] addr);
        return {2'b10, addr[15:2], ~addr[15:0]};
    endfunction

    function automatic void init_golden();
        logic [31:0] word;
        for (int a = 0; a < 16384; a += 4) begin
            word = pattern_word(32'(a));
            for (int b = 0; b < 4; b++)
                golden[14'(a + b)] = word[b*8 +: 8];
        end
    endfunction

    // the word a load must return after all earlier stores
    function automatic logic [31:0] expected_load(logic [31:0] addr);
        logic [13:0] base;
        base = {addr[13:2], 2'b00};
        return {golden[base + 14'd3], golden[base + 14'd2], golden[base + 14'd1], golden[base]};
    endfunction

    function automatic void store_golden(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
        logic [13:0] base;
        base = {addr[13:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                golden[base + 14'(b)] = data[b*8 +: 8];
        end
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // drive one request and hold it until the cache takes it
    task automatic issue(string name, bit is_store, logic [31:0] addr, logic [31:0] data,
                         logic [3:0] strb, bit fast);
        int waited;
        if (timed_out)
            return;
        waited    = 0;
        req_valid = 1'b1;
        req_write = is_store;
        req_addr  = addr;
        req_wdata = data;
        req_wstrb = strb;
        while (busy) begin
            if (waited == timeout_cycles) begin
                $display("timeout: cache stayed busy while %s waited to be accepted", name);
                timed_out = 1'b1;
                req_valid = 1'b0;
                return;
            end
            @(negedge clk);
            waited++;
        end
        exp_name.push_back(name);  // taken at the coming rising edge
        exp_load.push_back(!is_store);
        exp_data.push_back(is_store ? 32'd0 : expected_load(addr));
        exp_fast.push_back(fast);
        exp_cycle.push_back(cycle_cnt + 1);
        if (is_store)
            store_golden(addr, data, strb);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        if (timed_out)
            return;
        waited = 0;
        while (exp_name.size() != 0) begin
            if (waited == timeout_cycles) begin
                $display("timeout: no result arrived for request %s", exp_name[0]);
                timed_out = 1'b1;
                return;
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // first cycle after acceptance with busy low ends the access
    always @(negedge clk) begin
        if (exp_name.size() != 0 && cycle_cnt >= exp_cycle[0] && !busy) begin
            if (exp_load[0])
                check_value(exp_name[0], exp_data[0], rdata);
            if (exp_fast[0])
                check_value({exp_name[0], " latency"}, 32'd0, 32'(cycle_cnt - exp_cycle[0]));
            void'(exp_name.pop_front());
            void'(exp_data.pop_front());
            void'(exp_load.pop_front());
            void'(exp_fast.pop_front());
            void'(exp_cycle.pop_front());
        end
    end

    task automatic report_test(string name, int errs_before);
        test_count++;
        if (error_count == errs_before)
            $display("test %s: passed", name);
        else
            $display("test %s: %0d errors", name, error_count - errs_before);
    endtask

    task automatic cold_miss_reload();
        int errs;
        errs = error_count;
        issue("cold_load", 1'b0, 32'h0000_0010, '0, '0, 1'b0);
        issue("reload_word2", 1'b0, 32'h0000_0018, '0, '0, 1'b1);  // same line so it must hit
        drain();
        report_test("cold_miss_reload", errs);
    endtask

    task automatic store_merge();
        int errs;
        errs = error_count;
        issue("merge_fill", 1'b0, 32'h0000_0024, '0, '0, 1'b0);
        issue("merge_store_lo", 1'b1, 32'h0000_0024, 32'h1122_3344, 4'b0101, 1'b1);
        issue("merge_store_hi", 1'b1, 32'h0000_0024, 32'haabb_ccdd, 4'b1000, 1'b1);
        issue("merge_load", 1'b0, 32'h0000_0024, '0, '0, 1'b1);
        issue("merge_neighbour", 1'b0, 32'h0000_0020, '0, '0, 1'b1);
        drain();
        report_test("store_merge", errs);
    endtask

    task automatic clean_eviction();
        int errs;
        int wb_before;
        errs      = error_count;
        wb_before = wb_count;
        issue("evict_fill_a", 1'b0, 32'h0000_0040, '0, '0, 1'b0);
        issue("evict_fill_b", 1'b0, 32'h0000_0140, '0, '0, 1'b0);
        issue("evict_touch_a", 1'b0, 32'h0000_0044, '0, '0, 1'b1);
        issue("evict_load_c", 1'b0, 32'h0000_0240, '0, '0, 1'b0);  // b goes
        drain();
        check_value("evict_no_writeback", 32'(wb_before), 32'(wb_count));
        issue("evict_reload_a", 1'b0, 32'h0000_0048, '0, '0, 1'b1);
        drain();
        report_test("clean_eviction", errs);
    endtask

    task automatic dirty_writeback();
        int errs;
        int wb_before;
        errs = error_count;
        issue("wb_fill_a", 1'b0, 32'h0000_0054, '0, '0, 1'b0);
        issue("wb_store_a", 1'b1, 32'h0000_0054, 32'hdead_beef, 4'b1111, 1'b1);
        issue("wb_fill_b", 1'b0, 32'h0000_0150, '0, '0, 1'b0);
        drain();
        wb_before = wb_count;
        issue("wb_load_c", 1'b0, 32'h0000_0250, '0, '0, 1'b0);  // dirty a is the victim
        drain();
        check_value("wb_count", 32'(wb_before + 1), 32'(wb_count));
        check_value("wb_addr", 32'h0000_0050, last_wb_addr);
        for (int w = 0; w < 4; w++)
            check_value($sformatf("wb_data_w%0d", w), expected_load(32'h50 + 32'(w * 4)),
                        last_wb_data[w*32 +: 32]);
        issue("wb_reload_a", 1'b0, 32'h0000_0054, '0, '0, 1'b0);
        drain();
        check_value("rd_addr", 32'h0000_0050, last_rd_addr);  // line aligned
        report_test("dirty_writeback", errs);
    endtask

    // back to back traffic over sets 8 to 11 with six tags
    task automatic random_mix();
        int          errs;
        int          tag;
        int          set;
        int          wsel;
        bit          is_store;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        errs = error_count;
        for (int n = 0; n < 80; n++) begin
            tag      = int'($unsigned($random(seed)) % 6);
            set      = int'($unsigned($random(seed)) % 4);
            wsel     = int'($unsigned($random(seed)) % 4);
            is_store = 1'($random(seed));
            data     = $random(seed);
            strb     = 4'($random(seed));
            addr     = (tag << 8) | ((8 + set) << 4) | (wsel << 2);
            issue($sformatf("random_%0d", n), is_store, addr, data, strb, 1'b0);
        end
        drain();
        report_test("random_mix", errs);
    endtask

    initial begin
        seed        = 51;
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_wstrb   = '0;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        timed_out   = 1'b0;
        init_golden();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        if (!timed_out) cold_miss_reload();
        if (!timed_out) store_merge();
        if (!timed_out) clean_eviction();
        if (!timed_out) dirty_writeback();
        if (!timed_out) random_mix();

        $display("tests run: %0d, checks: %0d, errors: %0d", test_count, check_count,
                 error_count);
        if (error_count == 0 && !timed_out)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/mem_model.sv */
`default_nettype none

module mem_model (
    input  logic         clk,
    input  logic         reset,
    input  logic         mem_rd_req,
    input  logic [31:0]  mem_rd_addr,
    output logic         mem_rd_rdy,
    output logic         mem_ret_valid,
    output logic [127:0] mem_ret_data,
    input  logic         mem_wr_req,
    input  logic [31:0]  mem_wr_addr,
    input  logic [127:0] mem_wr_data,
    output logic         mem_wr_rdy,
    output logic         mem_wr_done,
    output int           wb_count,
    output logic [31:0]  last_wb_addr,
    output logic [127:0] last_wb_data,
    output logic [31:0]  last_rd_addr
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [127:0] store [1024];  // 16 KB backing store with one entry per line
    integer       seed = 51;

    // every word holds a value built from its own byte address
    function automatic logic [31:0] pattern_word(logic [31:0] addr);
        return {2'b10, addr[15:2], ~addr[15:0]};
    endfunction

    function automatic int random_delay();
        return int'($unsigned($random(seed)) % 6);
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            for (int w = 0; w < 4; w++)
                store[i[9:0]][w*32 +: 32] = pattern_word({18'd0, i[9:0], w[1:0], 2'b00});
        end
    end

    // line reads get rdy after a delay and the return pulse after another
    initial begin : read_port
        logic [31:0] addr;
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data  = '0;
        last_rd_addr  = '0;
        forever begin
            @(negedge clk);
            if (!reset && mem_rd_req) begin
                repeat (random_delay()) @(negedge clk);
                addr         = mem_rd_addr;
                last_rd_addr = mem_rd_addr;
                mem_rd_rdy   = 1'b1;
                @(negedge clk);
                mem_rd_rdy = 1'b0;
                repeat (random_delay()) @(negedge clk);
                mem_ret_data  = store[addr[13:4]];
                mem_ret_valid = 1'b1;
                @(negedge clk);
                mem_ret_valid = 1'b0;
            end
        end
    end

    initial begin : write_port
        mem_wr_rdy   = 1'b0;
        mem_wr_done  = 1'b0;
        wb_count     = 0;
        last_wb_addr = '0;
        last_wb_data = '0;
        forever begin
            @(negedge clk);
            if (!reset && mem_wr_req) begin
                repeat (random_delay()) @(negedge clk);
                last_wb_addr = mem_wr_addr;
                last_wb_data = mem_wr_data;
                store[mem_wr_addr[13:4]] = mem_wr_data;
                wb_count++;
                mem_wr_rdy = 1'b1;
                @(negedge clk);
                mem_wr_rdy = 1'b0;
                repeat (random_delay()) @(negedge clk);
                mem_wr_done = 1'b1;
                @(negedge clk);
                mem_wr_done = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
`default_nettype none

module dcache_top #(
    parameter int index_bits = 4,
    localparam int tag_bits  = 32 - dcache_pkg::offset_bits - index_bits
) (
    input  logic                                clk,
    input  logic                                reset,
    // cpu side
    input  logic                                req_valid,
    input  logic                                req_write,
    input  logic [31:0]                         req_addr,
    input  logic [dcache_pkg::word_bits-1:0]    req_wdata,
    input  logic [dcache_pkg::strb_bits-1:0]    req_wstrb,
    output logic [dcache_pkg::word_bits-1:0]    rdata,
    output logic                                busy,
    // memory side
    output logic                                mem_rd_req,
    output logic [31:0]                         mem_rd_addr,
    input  logic                                mem_rd_rdy,
    input  logic                                mem_ret_valid,
    input  logic [dcache_pkg::line_bits-1:0]    mem_ret_data,
    output logic                                mem_wr_req,
    output logic [31:0]                         mem_wr_addr,
    output logic [dcache_pkg::line_bits-1:0]    mem_wr_data,
    input  logic                                mem_wr_rdy,
    input  logic                                mem_wr_done
);

    logic                                              hit_way;
    logic [1:0][tag_bits-1:0]                          tag_rd;
    logic [1:0]                                        valid_rd;
    logic [1:0]                                        dirty_rd;
    dcache_pkg::line_t [1:0]                           line_rd;
    logic                                              plru_rd;
    logic [dcache_pkg::word_bits-1:0]                  merged_word;
    logic [1:0]                                        line_we;
    logic [1:0][dcache_pkg::words_per_line-1:0]        word_we;
    dcache_pkg::line_t                                 line_wdata;
    logic [1:0]                                        tag_we;
    logic                                              dirty_wdata;
    logic                                              plru_we;
    logic                                              plru_wdata;

    cache_req_if #(.index_bits(index_bits)) req_if ();

    dcache_decode #(.index_bits(index_bits)) dcache_decode_inst (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wstrb (req_wstrb),
        .busy      (busy),
        .req       (req_if.producer)
    );

    dcache_ctrl #(.index_bits(index_bits)) dcache_ctrl_inst (
        .clk           (clk),
        .reset         (reset),
        .req           (req_if.consumer),
        .tag_rd        (tag_rd),
        .valid_rd      (valid_rd),
        .dirty_rd      (dirty_rd),
        .line_rd       (line_rd),
        .plru_rd       (plru_rd),
        .merged_word   (merged_word),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data  (mem_ret_data),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_wr_done   (mem_wr_done),
        .busy          (busy),
        .hit_way       (hit_way),
        .line_we       (line_we),
        .word_we       (word_we),
        .line_wdata    (line_wdata),
        .tag_we        (tag_we),
        .dirty_wdata   (dirty_wdata),
        .plru_we       (plru_we),
        .plru_wdata    (plru_wdata),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_wr_req    (mem_wr_req),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data)
    );

    dcache_arrays #(.index_bits(index_bits)) dcache_arrays_inst (
        .clk         (clk),
        .reset       (reset),
        .index       (req_if.index),
        .tag_wdata   (req_if.tag),  // refill always installs the request's tag
        .tag_we      (tag_we),
        .line_we     (line_we),
        .word_we     (word_we),
        .word_sel    (req_if.word_sel),
        .line_wdata  (line_wdata),
        .dirty_wdata (dirty_wdata),
        .plru_we     (plru_we),
        .plru_wdata  (plru_wdata),
        .tag_rd      (tag_rd),
        .valid_rd    (valid_rd),
        .dirty_rd    (dirty_rd),
        .line_rd     (line_rd),
        .plru_rd     (plru_rd)
    );

    dcache_result dcache_result_inst (
        .req         (req_if.consumer),
        .line_rd     (line_rd),
        .hit_way     (hit_way),
        .rdata       (rdata),
        .merged_word (merged_word)
    );

endmodule

`default_nettype wire

/* rtl/dcache_result.sv */
`default_nettype none

module dcache_result (
    cache_req_if.consumer                     req,
    input  dcache_pkg::line_t [1:0]           line_rd,
    input  logic                              hit_way,
    output logic [dcache_pkg::word_bits-1:0]  rdata,
    output logic [dcache_pkg::word_bits-1:0]  merged_word
);

    localparam int byte_bits = dcache_pkg::word_bits / dcache_pkg::strb_bits;

    logic [dcache_pkg::word_bits-1:0] old_word;

    assign old_word = line_rd[hit_way].words[req.word_sel];
    assign rdata    = old_word;

    // strobed bytes from the store, the rest from the line
    always_comb begin
        for (int b = 0; b < dcache_pkg::strb_bits; b++) begin
            if (req.wstrb[b])
                merged_word[b*byte_bits +: byte_bits] = req.wdata[b*byte_bits +: byte_bits];
            else
                merged_word[b*byte_bits +: byte_bits] = old_word[b*byte_bits +: byte_bits];
        end
    end

endmodule

`default_nettype wire

/* cache_ctrl/dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl #(
    parameter int index_bits = 4,
    localparam int tag_bits  = 32 - dcache_pkg::offset_bits - index_bits
) (
    input  logic                                       clk,
    input  logic                                       reset,
    cache_req_if.consumer                              req,
    input  logic [1:0][tag_bits-1:0]                   tag_rd,
    input  logic [1:0]                                 valid_rd,
    input  logic [1:0]                                 dirty_rd,
    input  dcache_pkg::line_t [1:0]                    line_rd,
    input  logic                                       plru_rd,
    input  logic [dcache_pkg::word_bits-1:0]           merged_word,
    input  logic                                       mem_rd_rdy,
    input  logic                                       mem_ret_valid,
    input  logic [dcache_pkg::line_bits-1:0]           mem_ret_data,
    input  logic                                       mem_wr_rdy,
    input  logic                                       mem_wr_done,
    output logic                                       busy,
    output logic                                       hit_way,
    output logic [1:0]                                 line_we,
    output logic [1:0][dcache_pkg::words_per_line-1:0] word_we,
    output dcache_pkg::line_t                          line_wdata,
    output logic [1:0]                                 tag_we,
    output logic                                       dirty_wdata,
    output logic                                       plru_we,
    output logic                                       plru_wdata,
    output logic                                       mem_rd_req,
    output logic [31:0]                                mem_rd_addr,
    output logic                                       mem_wr_req,
    output logic [31:0]                                mem_wr_addr,
    output logic [dcache_pkg::line_bits-1:0]           mem_wr_data
);

    dcache_pkg::ctrl_state_t state, state_next;
    logic [1:0] way_hit;
    logic       hit;
    logic       complete;
    logic       refill_we;
    logic       victim_pick;
    logic       victim_way;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = req.valid & valid_rd[w] & (tag_rd[w] == req.tag);
        end
    end

    assign hit       = |way_hit;
    assign hit_way   = way_hit[1];
    assign complete  = hit & (state == dcache_pkg::lookup || state == dcache_pkg::done);
    assign refill_we = (state == dcache_pkg::refill) & mem_ret_valid;
    assign busy      = req.valid & ~complete;

    // invalid ways first, then the plru choice
    assign victim_pick = ~valid_rd[0] ? 1'b0 : (~valid_rd[1] ? 1'b1 : plru_rd);

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::lookup: begin
                if (req.valid && !hit) begin
                    if (valid_rd[victim_pick] && dirty_rd[victim_pick])
                        state_next = dcache_pkg::wb_req;
                    else
                        state_next = dcache_pkg::rd_req;
                end
            end
            dcache_pkg::wb_req:  if (mem_wr_rdy) state_next = dcache_pkg::wb_wait;
            dcache_pkg::wb_wait: if (mem_wr_done) state_next = dcache_pkg::rd_req;
            dcache_pkg::rd_req:  if (mem_rd_rdy) state_next = dcache_pkg::refill;
            dcache_pkg::refill:  if (mem_ret_valid) state_next = dcache_pkg::done;
            default:             state_next = dcache_pkg::lookup;  // done
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= dcache_pkg::lookup;
            victim_way <= 1'b0;
        end else begin
            state <= state_next;
            if (state == dcache_pkg::lookup)
                victim_way <= victim_pick;  // frozen for the rest of the miss
        end
    end

    // refill installs a clean line and a store hit writes one word
    always_comb begin
        line_we = '0;
        tag_we  = '0;
        word_we = '0;
        if (refill_we) begin
            line_we[victim_way] = 1'b1;
            tag_we[victim_way]  = 1'b1;
        end
        if (complete && req.write)
            word_we[hit_way][req.word_sel] = 1'b1;
    end

    always_comb begin
        if (refill_we) begin
            line_wdata.flat = mem_ret_data;
        end else begin
            line_wdata = '0;
            line_wdata.words[req.word_sel] = merged_word;
        end
    end

    assign dirty_wdata = ~refill_we;
    assign plru_we     = complete;
    assign plru_wdata  = ~hit_way;  // point away from the way just used

    assign mem_rd_req  = (state == dcache_pkg::rd_req);
    assign mem_rd_addr = {req.tag, req.index, {dcache_pkg::offset_bits{1'b0}}};
    assign mem_wr_req  = (state == dcache_pkg::wb_req);
    assign mem_wr_addr = {tag_rd[victim_way], req.index, {dcache_pkg::offset_bits{1'b0}}};
    assign mem_wr_data = line_rd[victim_way].flat;

endmodule

`default_nettype wire

/* cache_ctrl/dcache_arrays.sv */
`default_nettype none

module dcache_arrays #(
    parameter int index_bits = 4,
    localparam int tag_bits  = 32 - dcache_pkg::offset_bits - index_bits,
    localparam int sets      = 1 << index_bits
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [index_bits-1:0]                        index,
    input  logic [tag_bits-1:0]                          tag_wdata,
    input  logic [1:0]                                   tag_we,
    input  logic [1:0]                                   line_we,
    input  logic [1:0][dcache_pkg::words_per_line-1:0]   word_we,
    input  logic [$clog2(dcache_pkg::words_per_line)-1:0] word_sel,
    input  dcache_pkg::line_t                            line_wdata,
    input  logic                                         dirty_wdata,
    input  logic                                         plru_we,
    input  logic                                         plru_wdata,
    output logic [1:0][tag_bits-1:0]                     tag_rd,
    output logic [1:0]                                   valid_rd,
    output logic [1:0]                                   dirty_rd,
    output dcache_pkg::line_t [1:0]                      line_rd,
    output logic                                         plru_rd
);

    logic [sets-1:0] plru_q;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [tag_bits-1:0] tag_mem [sets];
        dcache_pkg::line_t   data_mem [sets];
        logic [sets-1:0]     valid_q;
        logic [sets-1:0]     dirty_q;

        always_ff @(posedge clk) begin
            if (tag_we[w])
                tag_mem[index] <= tag_wdata;
            for (int i = 0; i < dcache_pkg::words_per_line; i++) begin
                if (line_we[w])
                    data_mem[index].words[i] <= line_wdata.words[i];
                else if (word_we[w][i])
                    data_mem[index].words[i] <= line_wdata.words[word_sel];
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q <= '0;
                dirty_q <= '0;
            end else begin
                if (tag_we[w])
                    valid_q[index] <= 1'b1;
                if (line_we[w] || (|word_we[w]))
                    dirty_q[index] <= dirty_wdata;  // clean on refill, set on store
            end
        end

        assign tag_rd[w]   = tag_mem[index];
        assign valid_rd[w] = valid_q[index];
        assign dirty_rd[w] = dirty_q[index];
        assign line_rd[w]  = data_mem[index];
    end

    // one bit per set naming the way to evict next
    always_ff @(posedge clk) begin
        if (reset)
            plru_q <= '0;
        else if (plru_we)
            plru_q[index] <= plru_wdata;
    end

    assign plru_rd = plru_q[index];

endmodule

`default_nettype wire

/* rtl/dcache_decode.sv */
`default_nettype none

module dcache_decode #(
    parameter int index_bits = 4,
    localparam int tag_bits  = 32 - dcache_pkg::offset_bits - index_bits
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             req_valid,
    input  logic                             req_write,
    input  logic [31:0]                      req_addr,
    input  logic [dcache_pkg::word_bits-1:0] req_wdata,
    input  logic [dcache_pkg::strb_bits-1:0] req_wstrb,
    input  logic                             busy,
    cache_req_if.producer                    req
);

    logic take;

    assign take = req_valid & ~busy;

    // valid follows the cpu whenever the cache is free to accept
    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
        end else if (!busy) begin
            req.valid <= req_valid;
        end
    end

    // request payload, held while busy
    always_ff @(posedge clk) begin
        if (take) begin
            req.write    <= req_write;
            req.tag      <= req_addr[31 -: tag_bits];
            req.index    <= req_addr[dcache_pkg::offset_bits +: index_bits];
            req.word_sel <= req_addr[dcache_pkg::offset_bits-1:2];  // byte bits dropped
            req.wdata    <= req_wdata;
            req.wstrb    <= req_wstrb;
        end
    end

endmodule

`default_nettype wire

/* common/cache_req_if.sv */
`default_nettype none

// buffered request, already split into address fields
interface cache_req_if #(
    parameter int index_bits = 4
);

    localparam int tag_bits = 32 - dcache_pkg::offset_bits - index_bits;

    logic                                        valid;
    logic                                        write;
    logic [tag_bits-1:0]                         tag;
    logic [index_bits-1:0]                       index;
    logic [$clog2(dcache_pkg::words_per_line)-1:0] word_sel;
    logic [dcache_pkg::word_bits-1:0]            wdata;
    logic [dcache_pkg::strb_bits-1:0]            wstrb;

    modport producer (
        output valid, write, tag, index, word_sel, wdata, wstrb
    );

    modport consumer (
        input valid, write, tag, index, word_sel, wdata, wstrb
    );

endinterface

`default_nettype wire

/* common/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int word_bits      = 32;
    localparam int words_per_line = 4;
    localparam int offset_bits    = 4;  // byte offset inside a line
    localparam int strb_bits      = 4;  // one strobe per byte of a word
    localparam int line_bits      = word_bits * words_per_line;

    // a cache line, seen flat at the memory port or as words inside the cache
    typedef union packed {
        logic [line_bits-1:0]                     flat;
        logic [words_per_line-1:0][word_bits-1:0] words;  // word 0 in the low bits
    } line_t;

    // miss controller
    typedef enum logic [2:0] {
        lookup  = 3'd0,
        wb_req  = 3'd1,  // victim dirty, asking for the write port
        wb_wait = 3'd2,
        rd_req  = 3'd3,
        refill  = 3'd4,  // waiting for the return pulse
        done    = 3'd5
    } ctrl_state_t;

endpackage

`default_nettype wire
